//--- project.f
hw/ram_pkg.sv
hw/ram_bus_if.sv
hw/spram_bank.sv
hw/ram_a17.sv
hw/ram_ctrl_regs.sv
hw/ram_bus_decoder.sv
hw/ram_subsys_top.sv
tests/tb_clkgen.sv
tests/tb_ram_subsys.sv

//--- Makefile
# Verilator flow for the RAM subsystem; any variable can be set on the command line

VERILATOR ?= verilator
TOP       ?= tb_ram_subsys
RTL_TOP   ?= ram_subsys_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_ram_subsys.sv
/*
 * table-driven testbench for the RAM subsystem, BANK_WORDS cut to 1024
 * inputs change on the falling edge, outputs sampled SETTLE ns later
 * RAM reads are predicted from a shadow copy that also tracks sleep
 * only words inside the reduced bank depth are used
 */
`timescale 1ns/1ps

module tb_ram_subsys;

   localparam int SETTLE       = 5; // ns after the falling edge
   localparam int ACK_WAIT_MAX = 8; // cycles before giving up on ACK_O

   typedef enum int {WR, RD_RAM, RD_REG, RD_SLEEP} kind_e;

   typedef struct {
      string             name;
      kind_e             kind;
      ram_pkg::bus_adr_t adr;
      ram_pkg::word_t    dat;
      ram_pkg::sel_t     sel;
      ram_pkg::word_t    exp; // used by RD_REG and RD_SLEEP
   } entry_t;

   logic              clk;
   logic              arst_n;
   ram_pkg::bus_adr_t bus_adr;
   ram_pkg::word_t    bus_dat_w;
   ram_pkg::sel_t     bus_sel;
   logic              bus_we;
   logic              bus_stb;
   ram_pkg::word_t    bus_dat_r;
   logic              bus_ack;

   entry_t          tests_q[$];
   ram_pkg::word_t  shadow[int];     // word index -> expected contents
   ram_pkg::sleep_t model_sleep;     // sleep bits as last written
   ram_pkg::word_t  rnd[8];          // random fill words
   int              errors = 0;
   bit              test_bad;
   int              cycles = 0;
   int              cycle_limit = 100; // raised once the table is built

   tb_clkgen clkgen_inst (
      .clk    (clk),
      .arst_n (arst_n)
   );

   ram_subsys_top #(
      .BANK_WORDS (1024)
   ) ram_subsys_top_inst (
      .CLK_I  (clk),
      .arst_n (arst_n),
      .ADR_I  (bus_adr),
      .DAT_I  (bus_dat_w),
      .SEL_I  (bus_sel),
      .WE_I   (bus_we),
      .STB_I  (bus_stb),
      .DAT_O  (bus_dat_r),
      .ACK_O  (bus_ack)
   );

   // ---------------------------------------------------------------------
   // watchdog
   // ---------------------------------------------------------------------
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: no verdict after %0d clock cycles", cycle_limit);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // ---------------------------------------------------------------------
   // compare tasks
   // ---------------------------------------------------------------------
   task automatic check_word(input string name, input ram_pkg::word_t exp,
                             input ram_pkg::word_t act);
      if (act !== exp) begin
         $display("mismatch %s: expected %h, actual %h", name, exp, act);
         errors++;
         test_bad = 1'b1;
      end
   endtask

   task automatic check_ack_delay(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
         errors++;
         test_bad = 1'b1;
      end
   endtask

   task automatic check_sleep(input string name, input ram_pkg::sleep_t exp,
                              input ram_pkg::sleep_t act);
      if (act !== exp) begin
         $display("mismatch %s: expected %b, actual %b", name, exp, act);
         errors++;
         test_bad = 1'b1;
      end
   endtask

   // ---------------------------------------------------------------------
   // reference model
   // ---------------------------------------------------------------------
   function automatic ram_pkg::word_t merge_bytes(input ram_pkg::word_t old_w,
                                                  input ram_pkg::word_t new_w,
                                                  input ram_pkg::sel_t sel);
      ram_pkg::word_t res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[b*8 +: 8] = new_w[b*8 +: 8]; // selected lane only
         end
      end
      return res;
   endfunction

   task automatic apply_write(input ram_pkg::bus_adr_t adr, input ram_pkg::word_t dat,
                              input ram_pkg::sel_t sel);
      int             idx;
      ram_pkg::word_t old_w;
      idx = int'(adr[16:2]); // bit 16 keeps the halves apart
      if (adr[ram_pkg::RAM_SEL_BIT]) begin
         if (adr[16:2] == ram_pkg::REG_CTRL_OFS[16:2] && sel[0]) begin
            model_sleep = dat[1:0];
         end
      end else if (!model_sleep[adr[16]]) begin // sleeping half drops writes
         old_w = shadow.exists(idx) ? shadow[idx] : '0;
         shadow[idx] = merge_bytes(old_w, dat, sel);
      end
   endtask

   function automatic ram_pkg::word_t expect_ram(input ram_pkg::bus_adr_t adr);
      int idx;
      idx = int'(adr[16:2]);
      if (model_sleep[adr[16]] || !shadow.exists(idx)) begin
         return '0; // sleeping half reads zero
      end
      return shadow[idx];
   endfunction

   // ---------------------------------------------------------------------
   // bus access, returns the ack latency in cycles
   // ---------------------------------------------------------------------
   task automatic run_access(input ram_pkg::bus_adr_t adr, input logic we,
                             input ram_pkg::word_t dat, input ram_pkg::sel_t sel,
                             output int delay, output ram_pkg::word_t rdata,
                             output bit acked);
      int n;
      n = 0;
      @(negedge clk);
      bus_adr   = adr;
      bus_dat_w = dat;
      bus_sel   = sel;
      bus_we    = we;
      bus_stb   = 1'b1;
      #SETTLE;
      while (!bus_ack && n < ACK_WAIT_MAX) begin
         @(negedge clk);
         n++;
         #SETTLE;
      end
      acked = bus_ack;
      delay = n;
      rdata = bus_dat_r;
      @(negedge clk); // access committed at the edge in between
      bus_stb = 1'b0;
      bus_we  = 1'b0;
   endtask

   task automatic add_test(input string name, input kind_e kind, input ram_pkg::bus_adr_t adr,
                           input ram_pkg::word_t dat, input ram_pkg::sel_t sel,
                           input ram_pkg::word_t exp);
      entry_t e;
      e.name = name;
      e.kind = kind;
      e.adr  = adr;
      e.dat  = dat;
      e.sel  = sel;
      e.exp  = exp;
      tests_q.push_back(e);
   endtask

   // ---------------------------------------------------------------------
   // stimulus table, registers at 0x20000 (ctrl) and 0x20004 (status)
   // ---------------------------------------------------------------------
   task automatic build_tests();
      add_test("wr_h0_lo",      WR,       18'h00010, rnd[0], 4'hf, '0);
      add_test("wr_h1_alias",   WR,       18'h10010, rnd[1], 4'hf, '0); // same low bits
      add_test("wr_h0_hi",      WR,       18'h00ff0, rnd[2], 4'hf, '0);
      add_test("wr_h1_hi",      WR,       18'h10ff0, rnd[3], 4'hf, '0);
      add_test("rd_h0_lo",      RD_RAM,   18'h00010, '0, 4'hf, '0);
      add_test("rd_h1_alias",   RD_RAM,   18'h10010, '0, 4'hf, '0);
      add_test("rd_h0_hi",      RD_RAM,   18'h00ff0, '0, 4'hf, '0);
      add_test("rd_h1_hi",      RD_RAM,   18'h10ff0, '0, 4'hf, '0);
      // byte lanes
      add_test("wr_bytes_0_2",  WR,       18'h00010, rnd[4], 4'b0101, '0);
      add_test("rd_bytes_0_2",  RD_RAM,   18'h00010, '0, 4'hf, '0);
      add_test("wr_byte_3",     WR,       18'h10010, rnd[5], 4'b1000, '0);
      add_test("rd_byte_3",     RD_RAM,   18'h10010, '0, 4'hf, '0);
      // half 1 asleep
      add_test("wr_ctrl_sleep", WR,       18'h20000, 32'h2, 4'h1, '0);
      add_test("rd_ctrl_sleep", RD_SLEEP, 18'h20000, '0, 4'hf, 32'h2);
      add_test("rd_stat_mirr",  RD_REG,   18'h20004, '0, 4'hf, 32'h4);
      add_test("rd_h1_asleep",  RD_RAM,   18'h10010, '0, 4'hf, '0);
      add_test("rd_stat_err",   RD_REG,   18'h20004, '0, 4'hf, 32'h5);
      add_test("wr_h1_asleep",  WR,       18'h10010, rnd[6], 4'hf, '0);
      add_test("rd_h0_awake",   RD_RAM,   18'h00010, '0, 4'hf, '0);
      add_test("wr_h0_new",     WR,       18'h00020, rnd[7], 4'hf, '0);
      add_test("rd_h0_new",     RD_RAM,   18'h00020, '0, 4'hf, '0);
      add_test("wr_stat_zero",  WR,       18'h20004, 32'h0, 4'h1, '0); // not a clear
      add_test("rd_stat_sticky", RD_REG,  18'h20004, '0, 4'hf, 32'h5);
      add_test("wr_stat_clr",   WR,       18'h20004, 32'h1, 4'h1, '0);
      add_test("rd_stat_clr",   RD_REG,   18'h20004, '0, 4'hf, 32'h4);
      // wake up, old data still there
      add_test("wr_ctrl_wake",  WR,       18'h20000, 32'h0, 4'h1, '0);
      add_test("rd_ctrl_wake",  RD_SLEEP, 18'h20000, '0, 4'hf, 32'h0);
      add_test("rd_h1_kept",    RD_RAM,   18'h10010, '0, 4'hf, '0);
      add_test("rd_h1_hi_kept", RD_RAM,   18'h10ff0, '0, 4'hf, '0);
      add_test("rd_stat_idle",  RD_REG,   18'h20004, '0, 4'hf, 32'h0);
      // unmapped offsets
      add_test("wr_ctrl_h0",    WR,       18'h20000, 32'h1, 4'h1, '0);
      add_test("rd_h0_asleep",  RD_RAM,   18'h00010, '0, 4'hf, '0); // sets the sticky error
      add_test("wr_unmapped",   WR,       18'h20008, 32'hffff_ffff, 4'hf, '0);
      add_test("rd_unmapped",   RD_REG,   18'h20008, '0, 4'hf, 32'h0);
      add_test("rd_unmapped_2", RD_REG,   18'h20100, '0, 4'hf, 32'h0);
      add_test("rd_ctrl_same",  RD_SLEEP, 18'h20000, '0, 4'hf, 32'h1);
      add_test("rd_stat_same",  RD_REG,   18'h20004, '0, 4'hf, 32'h3);
      add_test("wr_ctrl_clear", WR,       18'h20000, 32'h0, 4'h1, '0);
   endtask

   // ---------------------------------------------------------------------
   // main sequence
   // ---------------------------------------------------------------------
   initial begin
      int             delay;
      int             exp_delay;
      int             passed;
      ram_pkg::word_t rdata;
      bit             acked;
      bit             is_wr;
      bus_adr     = '0;
      bus_dat_w   = '0;
      bus_sel     = '0;
      bus_we      = 1'b0;
      bus_stb     = 1'b0;
      model_sleep = '0;
      passed      = 0;
      void'($urandom(10)); // one seed for the run
      for (int i = 0; i < 8; i++) begin
         rnd[i] = $urandom();
      end
      build_tests();
      cycle_limit = tests_q.size() * 4 + 100;
      wait (arst_n === 1'b1);
      foreach (tests_q[i]) begin
         test_bad = 1'b0;
         is_wr    = (tests_q[i].kind == WR);
         run_access(tests_q[i].adr, is_wr, tests_q[i].dat, tests_q[i].sel,
                    delay, rdata, acked);
         if (!acked) begin
            $display("test %s: the DUT never raised the acknowledge", tests_q[i].name);
            errors++;
            test_bad = 1'b1;
         end else begin
            // RAM reads take one cycle, everything else none
            exp_delay = (is_wr || tests_q[i].adr[ram_pkg::RAM_SEL_BIT]) ? 0 : 1;
            check_ack_delay(tests_q[i].name, exp_delay, delay);
            case (tests_q[i].kind)
               WR:       apply_write(tests_q[i].adr, tests_q[i].dat, tests_q[i].sel);
               RD_RAM:   check_word(tests_q[i].name, expect_ram(tests_q[i].adr), rdata);
               RD_REG:   check_word(tests_q[i].name, tests_q[i].exp, rdata);
               default:  check_sleep(tests_q[i].name, tests_q[i].exp[1:0], rdata[1:0]);
            endcase
         end
         if (!test_bad) begin
            passed++;
         end
         $display("test %0d %s: %s", i, tests_q[i].name, test_bad ? "failed" : "passed");
      end
      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               tests_q.size(), passed, tests_q.size() - passed, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- tests/tb_clkgen.sv
/*
 * testbench clock and reset source
 * clk toggles every HALF_NS, arst_n held low for RST_CYCLES rising edges
 * reset is released on a falling edge, away from the active edge
 */
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int HALF_NS    = 20, // 40 ns period
   parameter int RST_CYCLES = 16
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk); // release mid-cycle
      arst_n = 1'b1;
   end

endmodule

//--- hw/ram_subsys_top.sv
/*
 * 128 KiB RAM subsystem with sleep control, plain strobe-level bus
 * write and register accesses ack in the stb cycle, RAM reads one later
 * master holds adr and stb until ACK_O, BANK_WORDS at most 16384
 */
`timescale 1ns/1ps

module ram_subsys_top #(
   parameter int BANK_WORDS = 16384 // depth of each 16-bit bank
) (
   input  logic              CLK_I,
   input  logic              arst_n,
   input  ram_pkg::bus_adr_t ADR_I,
   input  ram_pkg::word_t    DAT_I,
   input  ram_pkg::sel_t     SEL_I,
   input  logic              WE_I,
   input  logic              STB_I,
   output ram_pkg::word_t    DAT_O,
   output logic              ACK_O
);

   ram_pkg::sleep_t sleep;     // regs -> RAM
   logic            sleep_hit; // RAM -> regs

   // decoded channels
   ram_bus_if ram_ch ();
   ram_bus_if reg_ch ();

   ram_bus_decoder decoder_inst (
      .ADR_I  (ADR_I),
      .DAT_I  (DAT_I),
      .SEL_I  (SEL_I),
      .WE_I   (WE_I),
      .STB_I  (STB_I),
      .DAT_O  (DAT_O),
      .ACK_O  (ACK_O),
      .ram_ch (ram_ch.master),
      .reg_ch (reg_ch.master)
   );

   ram_a17 #(
      .BANK_WORDS (BANK_WORDS)
   ) ram_inst (
      .CLK_I     (CLK_I),
      .arst_n    (arst_n),
      .bus       (ram_ch.slave),
      .sleep     (sleep),
      .sleep_hit (sleep_hit)
   );

   ram_ctrl_regs regs_inst (
      .CLK_I     (CLK_I),
      .arst_n    (arst_n),
      .bus       (reg_ch.slave),
      .sleep_hit (sleep_hit),
      .sleep     (sleep)
   );

endmodule

//--- hw/ram_bus_decoder.sv
/*
 * splits the top-level bus into RAM and register channels
 * adr bit RAM_SEL_BIT set selects the registers
 * response comes from the addressed channel, data is zero without ack
 */
`timescale 1ns/1ps

module ram_bus_decoder (
   input  ram_pkg::bus_adr_t ADR_I,
   input  ram_pkg::word_t    DAT_I,
   input  ram_pkg::sel_t     SEL_I,
   input  logic              WE_I,
   input  logic              STB_I,
   output ram_pkg::word_t    DAT_O,
   output logic              ACK_O,
   ram_bus_if.master         ram_ch,
   ram_bus_if.master         reg_ch
);

   logic reg_sel; // 1 = register block addressed

   assign reg_sel = ADR_I[ram_pkg::RAM_SEL_BIT];

   // ---------------------------------------------------------------------
   // request fan-out
   // ---------------------------------------------------------------------
   assign ram_ch.adr   = ADR_I[ram_pkg::RAM_SEL_BIT-1:0];
   assign ram_ch.dat_w = DAT_I;
   assign ram_ch.sel   = SEL_I;
   assign ram_ch.we    = WE_I;
   assign ram_ch.stb   = STB_I & ~reg_sel; // strobe goes to one side

   assign reg_ch.adr   = ADR_I[ram_pkg::RAM_SEL_BIT-1:0];
   assign reg_ch.dat_w = DAT_I;
   assign reg_ch.sel   = SEL_I;
   assign reg_ch.we    = WE_I;
   assign reg_ch.stb   = STB_I & reg_sel;

   // ---------------------------------------------------------------------
   // response merge
   // ---------------------------------------------------------------------
   assign ACK_O = reg_sel ? reg_ch.ack : ram_ch.ack;

   always_comb begin
      if (reg_sel && reg_ch.ack) begin
         DAT_O = reg_ch.dat_r;
      end else if (!reg_sel && ram_ch.ack) begin
         DAT_O = ram_ch.dat_r;
      end else begin
         DAT_O = '0; // idle bus reads zero
      end
   end

endmodule

//--- hw/ram_ctrl_regs.sv
/*
 * control and status registers of the RAM subsystem
 * ack and read data are combinational, updates land on the ack edge
 * only the control and status words are mapped, the rest reads zero
 * writes use byte lane 0, the other lanes hold no bits
 */
`timescale 1ns/1ps

module ram_ctrl_regs (
   input  logic             CLK_I,
   input  logic             arst_n,
   ram_bus_if.slave         bus,
   input  logic             sleep_hit, // pulse from ram_a17
   output ram_pkg::sleep_t  sleep
);

   ram_pkg::sleep_t sleep_q; // control bits 1:0
   logic            err_q;   // sticky access error
   logic            hit_ctrl;
   logic            hit_stat;
   logic            wr_lane0; // write touching byte 0
   logic            err_clr;
   ram_pkg::word_t  ctrl_word;
   ram_pkg::word_t  stat_word;

   // ---------------------------------------------------------------------
   // decode, word address only
   // ---------------------------------------------------------------------
   assign hit_ctrl = (bus.adr[16:2] == ram_pkg::REG_CTRL_OFS[16:2]);
   assign hit_stat = (bus.adr[16:2] == ram_pkg::REG_STAT_OFS[16:2]);
   assign wr_lane0 = bus.stb & bus.we & bus.sel[0];

   // write 1 to clear
   assign err_clr = wr_lane0 & hit_stat & bus.dat_w[ram_pkg::STAT_ERR_BIT];

   // ---------------------------------------------------------------------
   // registers
   // ---------------------------------------------------------------------
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         sleep_q <= '0;
      end else if (wr_lane0 && hit_ctrl) begin
         sleep_q <= bus.dat_w[1:0];
      end
   end

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         err_q <= 1'b0;
      end else if (sleep_hit) begin
         err_q <= 1'b1; // set beats clear
      end else if (err_clr) begin
         err_q <= 1'b0;
      end
   end

   // ---------------------------------------------------------------------
   // read side
   // ---------------------------------------------------------------------
   always_comb begin
      ctrl_word      = '0;
      ctrl_word[1:0] = sleep_q;
   end

   always_comb begin
      stat_word = '0;
      stat_word[ram_pkg::STAT_ERR_BIT] = err_q;
      stat_word[ram_pkg::STAT_SLEEP_LSB +: 2] = sleep_q; // mirror
   end

   assign bus.dat_r = hit_ctrl ? ctrl_word :
                      hit_stat ? stat_word : '0; // unmapped reads zero

   assign bus.ack = bus.stb; // zero wait states
   assign sleep   = sleep_q;

endmodule

//--- hw/ram_a17.sv
/*
 * 128 KiB RAM, two 64 KiB halves of two 16-bit banks each
 * write ack is combinational, read ack comes one clock after stb
 * a held read stb gives one ack every second cycle
 * adr must stay stable until ack, read mux uses the live adr[16]
 */
`timescale 1ns/1ps

module ram_a17 #(
   parameter int BANK_WORDS = 16384
) (
   input  logic             CLK_I,
   input  logic             arst_n,
   ram_bus_if.slave         bus,
   input  ram_pkg::sleep_t  sleep,     // per half, from regs
   output logic             sleep_hit  // acked access to a sleeping half
);

   localparam int HALF_BIT = 16; // picks the 64 KiB half

   logic        write_stb;
   logic        read_stb;
   logic        rd_ack_q;   // read ack flop
   logic [7:0]  nib_mask;   // byte select widened to nibbles
   logic [1:0]  half_we;    // write enable per half
   logic [63:0] bank_dat;   // {half1, half0}, each {hi lane, lo lane}
   logic        half;       // addressed half

   assign half      = bus.adr[HALF_BIT];
   assign write_stb = bus.stb & bus.we;
   assign read_stb  = bus.stb & ~bus.we;

   // ---------------------------------------------------------------------
   // write steering
   // ---------------------------------------------------------------------
   assign nib_mask = {{2{bus.sel[3]}}, {2{bus.sel[2]}},
                      {2{bus.sel[1]}}, {2{bus.sel[0]}}};

   assign half_we[0] = write_stb & ~half;
   assign half_we[1] = write_stb &  half;

   // ---------------------------------------------------------------------
   // banks, j = half, k = 16-bit lane
   // ---------------------------------------------------------------------
   for (genvar j = 0; j < 2; j++) begin : g_half
      for (genvar k = 0; k < 2; k++) begin : g_lane
         spram_bank #(
            .BANK_WORDS (BANK_WORDS)
         ) bank_inst (
            .CLK_I (CLK_I),
            .adr   (bus.adr[15:2]),            // word within the half
            .dat_w (bus.dat_w[k*16 +: 16]),
            .mask  (nib_mask[k*4 +: 4]),
            .wren  (half_we[j]),
            .sleep (sleep[j]),
            .dat_r (bank_dat[j*32 + k*16 +: 16])
         );
      end
   end

   // ---------------------------------------------------------------------
   // acknowledge sequencing
   // ---------------------------------------------------------------------
   // set by a read stb, forced low the cycle after it was high
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         rd_ack_q <= 1'b0;
      end else begin
         rd_ack_q <= read_stb & ~rd_ack_q;
      end
   end

   assign bus.ack = write_stb | rd_ack_q;

   // adr held until ack, so no need to pipeline the half select
   assign bus.dat_r = half ? bank_dat[63:32] : bank_dat[31:0];

   // flags the error once per access, in its ack cycle
   assign sleep_hit = bus.ack & sleep[half];

endmodule

//--- hw/spram_bank.sv
/*
 * behavioural 16-bit single-port RAM bank with nibble write mask
 * read data is registered, valid one clock after the address
 * BANK_WORDS must not exceed 16384, addresses at or above it read zero
 * sleep blocks writes and zeroes the output, contents are kept
 */
`timescale 1ns/1ps

module spram_bank #(
   parameter int BANK_WORDS = 16384
) (
   input  logic        CLK_I,
   input  logic [13:0] adr,   // word address
   input  logic [15:0] dat_w,
   input  logic [3:0]  mask,  // one bit per nibble, 1 = write
   input  logic        wren,
   input  logic        sleep,
   output logic [15:0] dat_r
);

   localparam int AW = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

   logic [15:0]   mem [BANK_WORDS]; // storage, no reset
   logic [15:0]   rd_q;             // output register
   logic          in_range;         // adr inside the modelled depth
   logic [AW-1:0] idx;

   // smaller depths are for quick sims, upper words just do not exist
   assign in_range = (int'(adr) < BANK_WORDS);
   assign idx      = adr[AW-1:0];

   // ---------------------------------------------------------------------
   // write port
   // ---------------------------------------------------------------------
   always_ff @(posedge CLK_I) begin
      if (wren && !sleep && in_range) begin
         for (int n = 0; n < 4; n++) begin
            if (mask[n]) begin
               mem[idx][n*4 +: 4] <= dat_w[n*4 +: 4]; // masked nibble
            end
         end
      end
   end

   // ---------------------------------------------------------------------
   // read port
   // ---------------------------------------------------------------------
   // read before write on a same-cycle write, like the hard macro
   always_ff @(posedge CLK_I) begin
      if (sleep || !in_range) begin
         rd_q <= '0; // sleeping macro drives zero
      end else begin
         rd_q <= mem[idx];
      end
   end

   assign dat_r = rd_q;

endmodule

//--- hw/ram_bus_if.sv
/*
 * one decoded strobe-level bus channel
 * master holds adr, dat_w, sel, we and stb until ack is seen
 * no back-pressure beyond ack, one access in flight at most
 */
`timescale 1ns/1ps

interface ram_bus_if;

   ram_pkg::ram_adr_t adr;   // byte address inside the target
   ram_pkg::word_t    dat_w; // write data
   ram_pkg::sel_t     sel;   // byte lanes
   logic              we;    // level, 1 = write
   logic              stb;   // level, access requested
   ram_pkg::word_t    dat_r; // read data, valid with ack
   logic              ack;   // access done this cycle

   // decoder side
   modport master (
      output adr,
      output dat_w,
      output sel,
      output we,
      output stb,
      input  dat_r,
      input  ack
   );

   // target side
   modport slave (
      input  adr,
      input  dat_w,
      input  sel,
      input  we,
      input  stb,
      output dat_r,
      output ack
   );

endinterface

//--- hw/ram_pkg.sv
/*
 * shared widths, bus types and register offsets for the RAM subsystem
 * byte addresses throughout, the RAM and the registers are word wide
 * bit RAM_SEL_BIT of the top-level address picks the register block
 */
package ram_pkg;

   // ---------------------------------------------------------------------
   // bus types
   // ---------------------------------------------------------------------
   typedef logic [31:0] word_t;    // data word on bus and in registers
   typedef logic [3:0]  sel_t;     // one bit per byte lane
   typedef logic [16:0] ram_adr_t; // byte address inside 128 KiB
   typedef logic [17:0] bus_adr_t; // top-level byte address

   // one sleep request per RAM half, bit 0 is the half with adr[16] clear
   typedef logic [1:0]  sleep_t;

   // ---------------------------------------------------------------------
   // address map
   // ---------------------------------------------------------------------
   localparam int RAM_SEL_BIT = 17; // set -> register block

   // control register, bits 1:0 are the sleep requests
   localparam ram_adr_t REG_CTRL_OFS = 17'h0_0000;

   // status register
   //   bit 0    sticky error, write 1 to clear
   //   bits 2:1 mirror of the sleep bits
   localparam ram_adr_t REG_STAT_OFS = 17'h0_0004;

   // status bit positions
   localparam int STAT_ERR_BIT   = 0;
   localparam int STAT_SLEEP_LSB = 1;

endpackage
